// File: hw/hbm_ctrl_cfg.svh
// HBM management address map, register offsets and local reset hold length
`ifndef HBM_CTRL_CFG_SVH
`define HBM_CTRL_CFG_SVH

// ------------------------------------------------------------
// Host address map
// ------------------------------------------------------------
// Host address bit that selects the channel window
`define HBM_CHAN_WINDOW_BIT 19

// Width of the offset inside either window
`define HBM_CHAN_OFFSET_BITS 17

// ------------------------------------------------------------
// Register window offsets
// ------------------------------------------------------------
// Bit 0 soft reset
`define HBM_REG_CONTROL     17'h0_0000
// Bit 0 local reset active, bit 1 init done
`define HBM_REG_STATUS      17'h0_0004
// Bit 0 cattrip, bits 7:1 temperature
`define HBM_REG_DRAM_STATUS 17'h0_0008
// Bits 2:0 memory controller index
`define HBM_REG_CHAN_SEL    17'h0_000C

// Cycles the local reset stays up after its cause drops
`define HBM_RESET_HOLD 4

`endif

// File: hw/hbm_ctrl_pkg.sv
// HBM management types shared by the decoder, register block and APB bridge
package hbm_ctrl_pkg;

    // ------------------------------------------------------------
    // Host register port
    // ------------------------------------------------------------
    // Bit 19 picks the channel window, bits 16:0 are the offset
    typedef logic [19:0] host_addr_t;

    // Register and APB data word
    typedef logic [31:0] reg_data_t;

    // ------------------------------------------------------------
    // Memory stack management port
    // ------------------------------------------------------------
    // Controller code on top of the 17-bit channel offset
    typedef logic [21:0] apb_addr_t;

    // Memory controller index, 0 to 7
    typedef logic [2:0]  chan_sel_t;

    // Interleaved select code placed in paddr[21:17]
    typedef logic [4:0]  chan_code_t;

    // DRAM temperature reading
    typedef logic [6:0]  dram_temp_t;

    // ------------------------------------------------------------
    // APB bridge FSM
    // ------------------------------------------------------------
    typedef enum logic [1:0] {
        apb_idle    = 2'd0,
        apb_setup   = 2'd1,
        apb_access  = 2'd2,
        apb_respond = 2'd3
    } apb_state_t;

endpackage : hbm_ctrl_pkg

// File: hw/hbm_host_if.sv
// Host request and response bundle for one register window
`timescale 1ns/1ns

interface hbm_host_if
    import hbm_ctrl_pkg::*;
();

    // Request side, req is a single-cycle strobe
    logic       req;
    logic       wr;
    host_addr_t addr;
    reg_data_t  wdata;

    // Response side, ack is a single-cycle pulse
    // rdata and err only count while ack is high
    logic       ack;
    reg_data_t  rdata;
    logic       err;

    // Side that issues requests
    modport initiator (
        output req, wr, addr, wdata,
        input  ack, rdata, err
    );

    // Side that answers them
    modport target (
        input  req, wr, addr, wdata,
        output ack, rdata, err
    );

endinterface : hbm_host_if

// File: hw/hbm_ctrl_decoder.sv
// Host window decoder splitting requests between registers and the APB bridge
`timescale 1ns/1ns
`include "hbm_ctrl_cfg.svh"

module hbm_ctrl_decoder (
    hbm_host_if.target    host,
    hbm_host_if.initiator reg_bus,
    hbm_host_if.initiator chan_bus
);

    logic chan_hit;

    // ------------------------------------------------------------
    // Request steering
    // ------------------------------------------------------------
    // Window select straight from the address
    assign chan_hit = host.addr[`HBM_CHAN_WINDOW_BIT];

    // Strobe goes to one window only
    assign reg_bus.req  = host.req & ~chan_hit;
    assign chan_bus.req = host.req &  chan_hit;

    // Payload fanned out to both, qualified by req
    assign reg_bus.wr     = host.wr;
    assign reg_bus.addr   = host.addr;
    assign reg_bus.wdata  = host.wdata;
    assign chan_bus.wr    = host.wr;
    assign chan_bus.addr  = host.addr;
    assign chan_bus.wdata = host.wdata;

    // ------------------------------------------------------------
    // Response merge
    // ------------------------------------------------------------
    // One request outstanding, so at most one ack per cycle
    assign host.ack = reg_bus.ack | chan_bus.ack;

    // Take data from whichever window answered
    always_comb begin
        if (chan_bus.ack) begin
            host.rdata = chan_bus.rdata;
            host.err   = chan_bus.err;
        end else begin
            host.rdata = reg_bus.rdata;
            host.err   = reg_bus.err;
        end
    end

endmodule : hbm_ctrl_decoder

// File: hw/hbm_ctrl_regs.sv
// HBM local register block with status synchronizers and local reset hold
`timescale 1ns/1ns
`include "hbm_ctrl_cfg.svh"

module hbm_ctrl_regs
    import hbm_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       i_reset,
    hbm_host_if.target bus,
    input  logic       i_init_done,
    input  logic       i_dram_cattrip,
    input  dram_temp_t i_dram_temp,
    output chan_sel_t  o_chan_sel,
    output logic       o_local_reset
);

    localparam int HOLD_W = $clog2(`HBM_RESET_HOLD + 1);
    // init_done, temperature and cattrip
    localparam int STAT_W = $bits(dram_temp_t) + 2;

    logic [`HBM_CHAN_OFFSET_BITS-1:0] offset;
    logic                             soft_reset;
    chan_sel_t                        chan_sel;
    logic [STAT_W-1:0]                stat_meta;
    logic [STAT_W-1:0]                stat_sync;
    logic                             init_done_s;
    logic                             cattrip_s;
    dram_temp_t                       temp_s;
    logic [HOLD_W-1:0]                hold_cnt;
    reg_data_t                        rd_data;
    logic                             rd_err;
    logic                             ack_q;
    reg_data_t                        rdata_q;
    logic                             err_q;

    assign offset = bus.addr[`HBM_CHAN_OFFSET_BITS-1:0];

    // ------------------------------------------------------------
    // Status input synchronizers
    // ------------------------------------------------------------
    // Two flops per bit, inputs come from another clock domain
    always_ff @(posedge clk) begin
        if (i_reset) begin
            stat_meta <= '0;
            stat_sync <= '0;
        end else begin
            stat_meta <= {i_init_done, i_dram_temp, i_dram_cattrip};
            stat_sync <= stat_meta;
        end
    end

    assign {init_done_s, temp_s, cattrip_s} = stat_sync;

    // ------------------------------------------------------------
    // Local reset hold
    // ------------------------------------------------------------
    // Reload while either cause is up, count down after both drop
    always_ff @(posedge clk) begin
        if (i_reset || soft_reset) begin
            hold_cnt <= HOLD_W'(`HBM_RESET_HOLD);
        end else if (hold_cnt != '0) begin
            hold_cnt <= hold_cnt - 1'b1;
        end
    end

    assign o_local_reset = i_reset | soft_reset | (hold_cnt != '0);

    // ------------------------------------------------------------
    // Writable registers
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (i_reset) begin
            soft_reset <= 1'b0;
            chan_sel   <= '0;
        end else if (bus.req && bus.wr) begin
            case (offset)
                `HBM_REG_CONTROL:  soft_reset <= bus.wdata[0];
                `HBM_REG_CHAN_SEL: chan_sel   <= bus.wdata[2:0];
                // Status registers are read-only, writes dropped
                default: ;
            endcase
        end
    end

    assign o_chan_sel = chan_sel;

    // Read mux, unmapped offsets flag an error
    always_comb begin
        rd_data = '0;
        rd_err  = 1'b0;
        case (offset)
            `HBM_REG_CONTROL:     rd_data[0]   = soft_reset;
            `HBM_REG_STATUS:      rd_data[1:0] = {init_done_s, o_local_reset};
            `HBM_REG_DRAM_STATUS: rd_data[7:0] = {temp_s, cattrip_s};
            `HBM_REG_CHAN_SEL:    rd_data[2:0] = chan_sel;
            default:              rd_err       = 1'b1;
        endcase
    end

    // ------------------------------------------------------------
    // Response, one cycle after the request
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (i_reset) begin
            ack_q <= 1'b0;
            err_q <= 1'b0;
        end else begin
            ack_q <= bus.req;
            err_q <= bus.req & rd_err;
        end
    end

    // Captured data word
    always_ff @(posedge clk) begin
        if (bus.req) begin
            rdata_q <= rd_data;
        end
    end

    assign bus.ack   = ack_q;
    assign bus.rdata = rdata_q;
    assign bus.err   = err_q;

endmodule : hbm_ctrl_regs

// File: hw/hbm_apb_bridge.sv
// Host to APB bridge for the memory stack management port
`timescale 1ns/1ns
`include "hbm_ctrl_cfg.svh"

module hbm_apb_bridge
    import hbm_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       i_reset,
    hbm_host_if.target bus,
    input  chan_sel_t  i_chan_sel,
    output apb_addr_t  o_paddr,
    output logic       o_psel,
    output logic       o_penable,
    output logic       o_pwrite,
    output reg_data_t  o_pwdata,
    input  logic       i_pready,
    input  reg_data_t  i_prdata,
    input  logic       i_pslverr
);

    apb_state_t state;
    apb_state_t state_nxt;
    chan_code_t chan_code;
    apb_addr_t  paddr_q;
    logic       pwrite_q;
    reg_data_t  pwdata_q;
    reg_data_t  prdata_q;
    logic       pslverr_q;

    // ------------------------------------------------------------
    // Controller select encoding
    // ------------------------------------------------------------
    // Interleaved map, index bit 0 lands in code bit 2
    always_comb begin
        case (i_chan_sel)
            3'd0:    chan_code = 5'b01000;
            3'd1:    chan_code = 5'b01100;
            3'd2:    chan_code = 5'b01001;
            3'd3:    chan_code = 5'b01101;
            3'd4:    chan_code = 5'b01010;
            3'd5:    chan_code = 5'b01110;
            3'd6:    chan_code = 5'b01011;
            default: chan_code = 5'b01111;
        endcase
    end

    // ------------------------------------------------------------
    // Transfer FSM
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (i_reset) begin
            state <= apb_idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            apb_idle:    if (bus.req) state_nxt = apb_setup;
            apb_setup:   state_nxt = apb_access;
            // Wait states hold the access phase
            apb_access:  if (i_pready) state_nxt = apb_respond;
            apb_respond: state_nxt = apb_idle;
            default:     state_nxt = apb_idle;
        endcase
    end

    // Request capture, code fixed for the whole transfer
    always_ff @(posedge clk) begin
        if (state == apb_idle && bus.req) begin
            paddr_q  <= {chan_code, bus.addr[`HBM_CHAN_OFFSET_BITS-1:0]};
            pwrite_q <= bus.wr;
            pwdata_q <= bus.wdata;
        end
        if (state == apb_access && i_pready) begin
            prdata_q <= i_prdata;
        end
    end

    // Slave error, kept low out of reset
    always_ff @(posedge clk) begin
        if (i_reset) begin
            pslverr_q <= 1'b0;
        end else if (state == apb_access && i_pready) begin
            pslverr_q <= i_pslverr;
        end
    end

    // ------------------------------------------------------------
    // APB and host outputs
    // ------------------------------------------------------------
    assign o_psel    = (state == apb_setup) || (state == apb_access);
    assign o_penable = (state == apb_access);
    assign o_paddr   = paddr_q;
    assign o_pwrite  = pwrite_q;
    assign o_pwdata  = pwdata_q;

    // Ack in the cycle after pready is sampled
    assign bus.ack   = (state == apb_respond);
    assign bus.rdata = prdata_q;
    assign bus.err   = pslverr_q;

endmodule : hbm_apb_bridge

// File: hw/hbm_ctrl_top.sv
// HBM management subsystem top joining the window decoder, registers and APB bridge
`timescale 1ns/1ns

module hbm_ctrl_top
    import hbm_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       i_reset,
    // Host register port
    input  logic       i_reg_req,
    input  logic       i_reg_wr,
    input  host_addr_t i_reg_addr,
    input  reg_data_t  i_reg_wdata,
    output logic       o_reg_ack,
    output reg_data_t  o_reg_rdata,
    output logic       o_reg_err,
    // Management APB port
    output apb_addr_t  o_paddr,
    output logic       o_psel,
    output logic       o_penable,
    output logic       o_pwrite,
    output reg_data_t  o_pwdata,
    input  logic       i_pready,
    input  reg_data_t  i_prdata,
    input  logic       i_pslverr,
    // DRAM status
    input  logic       i_init_done,
    input  logic       i_dram_cattrip,
    input  dram_temp_t i_dram_temp,
    output logic       o_local_reset
);

    chan_sel_t chan_sel;

    hbm_host_if host_bus ();
    hbm_host_if reg_bus ();
    hbm_host_if chan_bus ();

    // ------------------------------------------------------------
    // Host port onto the internal bus
    // ------------------------------------------------------------
    assign host_bus.req   = i_reg_req;
    assign host_bus.wr    = i_reg_wr;
    assign host_bus.addr  = i_reg_addr;
    assign host_bus.wdata = i_reg_wdata;
    assign o_reg_ack      = host_bus.ack;
    assign o_reg_rdata    = host_bus.rdata;
    assign o_reg_err      = host_bus.err;

    hbm_ctrl_decoder i_hbm_ctrl_decoder (
        .host     ( host_bus ),
        .reg_bus  ( reg_bus ),
        .chan_bus ( chan_bus )
    );

    // Register window
    hbm_ctrl_regs i_hbm_ctrl_regs (
        .clk            ( clk ),
        .i_reset        ( i_reset ),
        .bus            ( reg_bus ),
        .i_init_done    ( i_init_done ),
        .i_dram_cattrip ( i_dram_cattrip ),
        .i_dram_temp    ( i_dram_temp ),
        .o_chan_sel     ( chan_sel ),
        .o_local_reset  ( o_local_reset )
    );

    // Channel window
    hbm_apb_bridge i_hbm_apb_bridge (
        .clk        ( clk ),
        .i_reset    ( i_reset ),
        .bus        ( chan_bus ),
        .i_chan_sel ( chan_sel ),
        .o_paddr    ( o_paddr ),
        .o_psel     ( o_psel ),
        .o_penable  ( o_penable ),
        .o_pwrite   ( o_pwrite ),
        .o_pwdata   ( o_pwdata ),
        .i_pready   ( i_pready ),
        .i_prdata   ( i_prdata ),
        .i_pslverr  ( i_pslverr )
    );

endmodule : hbm_ctrl_top

// File: dv/hbm_ctrl_props.sv
// APB phase and host acknowledge protocol assertions bound to the HBM management top
`timescale 1ns/1ns

module hbm_ctrl_props
    import hbm_ctrl_pkg::*;
(
    input logic      clk,
    input logic      i_reset,
    input logic      i_psel,
    input logic      i_penable,
    input apb_addr_t i_paddr,
    input logic      i_pwrite,
    input logic      i_pready,
    input logic      i_reg_ack,
    input logic      i_local_reset
);

    // ------------------------------------------------------------
    // APB phases
    // ------------------------------------------------------------
    // Access phase only inside a selected transfer
    a_penable_psel: assert property (@(posedge clk) disable iff (i_reset)
        i_penable |-> i_psel)
        else $error("penable high without psel");

    // Address and direction frozen through wait states
    a_phase_stable: assert property (@(posedge clk) disable iff (i_reset)
        (i_psel && !i_pready) |=> ($stable(i_paddr) && $stable(i_pwrite)))
        else $error("paddr or pwrite changed while the transfer was held");

    // ------------------------------------------------------------
    // Host side and local reset
    // ------------------------------------------------------------
    // Single-cycle ack pulse
    a_ack_pulse: assert property (@(posedge clk) disable iff (i_reset)
        i_reg_ack |=> !i_reg_ack)
        else $error("o_reg_ack held for more than one cycle");

    a_reset_local: assert property (@(posedge clk)
        i_reset |-> i_local_reset)
        else $error("o_local_reset low during system reset");

endmodule : hbm_ctrl_props

bind hbm_ctrl_top hbm_ctrl_props i_hbm_ctrl_props (
    .clk           ( clk ),
    .i_reset       ( i_reset ),
    .i_psel        ( o_psel ),
    .i_penable     ( o_penable ),
    .i_paddr       ( o_paddr ),
    .i_pwrite      ( o_pwrite ),
    .i_pready      ( i_pready ),
    .i_reg_ack     ( o_reg_ack ),
    .i_local_reset ( o_local_reset )
);

// File: dv/hbm_ctrl_tb.sv
// Vector driven testbench for the HBM management subsystem with an APB target model
`timescale 1ns/1ns
`include "hbm_ctrl_cfg.svh"

module hbm_ctrl_tb
    import hbm_ctrl_pkg::*;
();

    localparam int MAX_VEC = 64;
    localparam int TIMEOUT = 200;

    logic        clk;
    logic        i_reset;
    logic        reg_req;
    logic        reg_wr;
    host_addr_t  reg_addr;
    reg_data_t   reg_wdata;
    logic        reg_ack;
    reg_data_t   reg_rdata;
    logic        reg_err;
    apb_addr_t   paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    reg_data_t   pwdata;
    logic        pready;
    reg_data_t   prdata;
    logic        pslverr;
    logic        init_done;
    logic        dram_cattrip;
    dram_temp_t  dram_temp;
    logic        local_reset;

    // One line per operation, see the vector file header for columns
    logic [99:0] vectors [MAX_VEC];
    reg_data_t   apb_mem [64];
    int          error_count;
    bit          timed_out;
    int          cycle_cnt = 0;
    int          wait_states;
    int          ready_cycle;
    apb_addr_t   seen_paddr;

    hbm_ctrl_top i_hbm_ctrl_top (
        .clk            ( clk ),
        .i_reset        ( i_reset ),
        .i_reg_req      ( reg_req ),
        .i_reg_wr       ( reg_wr ),
        .i_reg_addr     ( reg_addr ),
        .i_reg_wdata    ( reg_wdata ),
        .o_reg_ack      ( reg_ack ),
        .o_reg_rdata    ( reg_rdata ),
        .o_reg_err      ( reg_err ),
        .o_paddr        ( paddr ),
        .o_psel         ( psel ),
        .o_penable      ( penable ),
        .o_pwrite       ( pwrite ),
        .o_pwdata       ( pwdata ),
        .i_pready       ( pready ),
        .i_prdata       ( prdata ),
        .i_pslverr      ( pslverr ),
        .i_init_done    ( init_done ),
        .i_dram_cattrip ( dram_cattrip ),
        .i_dram_temp    ( dram_temp ),
        .o_local_reset  ( local_reset )
    );

    // ------------------------------------------------------------
    // Clock and cycle count
    // ------------------------------------------------------------
    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // ------------------------------------------------------------
    // APB target model
    // ------------------------------------------------------------
    // 0 to 3 wait states, pslverr when paddr bit 16 is set
    initial begin
        void'($urandom(32'h4b222d93));
        pready      = 1'b0;
        prdata      = '0;
        pslverr     = 1'b0;
        wait_states = 0;
        ready_cycle = 0;
        seen_paddr  = '0;
        for (int i = 0; i < 64; i++) begin
            apb_mem[i] = 32'h5A00_0000 ^ (i * 32'h0101_0101);
        end
        forever begin
            @(posedge clk);
            #2;
            if (pready) begin
                // Transfer finished at the last edge
                pready  = 1'b0;
                pslverr = 1'b0;
            end else if (psel && !penable) begin
                // Setup phase, pick the wait states
                seen_paddr  = paddr;
                wait_states = int'($urandom % 4);
            end else if (psel) begin
                if (wait_states == 0) begin
                    pready      = 1'b1;
                    // Edge that samples pready high
                    ready_cycle = cycle_cnt + 1;
                    pslverr     = paddr[16];
                    prdata      = '0;
                    if (!paddr[16]) begin
                        if (pwrite) begin
                            apb_mem[paddr[7:2]] = pwdata;
                        end else begin
                            prdata = apb_mem[paddr[7:2]];
                        end
                    end
                end else begin
                    wait_states = wait_states - 1;
                end
            end
        end
    end

    // ------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------
    task automatic check_data(input string name, input reg_data_t exp, input reg_data_t act);
        if (act !== exp) begin
            error_count++;
            $display("MISMATCH t=%0t %s expected %08h got %08h", $time, name, exp, act);
        end
    endtask

    task automatic check_paddr(input string name, input apb_addr_t exp, input apb_addr_t act);
        if (act !== exp) begin
            error_count++;
            $display("MISMATCH t=%0t %s expected %06h got %06h", $time, name, exp, act);
        end
    endtask

    task automatic check_err(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            error_count++;
            $display("MISMATCH t=%0t %s expected %0b got %0b", $time, name, exp, act);
        end
    endtask

    task automatic check_cycles(input string name, input int exp, input int act);
        if (act != exp) begin
            error_count++;
            $display("MISMATCH t=%0t %s expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    // Timeouts count as errors and end the vector loop
    task automatic report_timeout(input string reason);
        error_count++;
        timed_out = 1'b1;
        $display("%s", reason);
    endtask

    // ------------------------------------------------------------
    // Host port driver
    // ------------------------------------------------------------
    // Entered and left 2 ns after a rising edge
    task automatic host_access(input logic wr, input host_addr_t addr, input reg_data_t wdata,
                               output reg_data_t rdata, output logic err,
                               output int req_cycle, output int ack_cycle);
        int waited;
        waited    = 0;
        reg_req   = 1'b1;
        reg_wr    = wr;
        reg_addr  = addr;
        reg_wdata = wdata;
        @(posedge clk);
        #2;
        reg_req   = 1'b0;
        req_cycle = cycle_cnt;
        while (!reg_ack && waited < TIMEOUT) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (!reg_ack) begin
            report_timeout("Timeout, no o_reg_ack within 200 cycles");
        end
        ack_cycle = cycle_cnt;
        rdata     = reg_rdata;
        err       = reg_err;
        // Bridge needs one cycle to get back to idle
        @(posedge clk);
        #2;
    endtask

    task automatic run_access(input logic wr, input host_addr_t addr, input reg_data_t wdata,
                              input reg_data_t exp_rdata, input logic exp_err,
                              input chan_code_t exp_code);
        reg_data_t rdata;
        logic      err;
        int        req_cycle;
        int        ack_cycle;
        host_access(wr, addr, wdata, rdata, err, req_cycle, ack_cycle);
        if (timed_out) begin
            return;
        end
        if (!wr) begin
            check_data("o_reg_rdata", exp_rdata, rdata);
        end
        check_err("o_reg_err", exp_err, err);
        if (addr[`HBM_CHAN_WINDOW_BIT]) begin
            // Code on top of the untouched 17-bit offset
            check_paddr("o_paddr", {exp_code, addr[16:0]}, seen_paddr);
            check_cycles("o_reg_ack cycle", ready_cycle, ack_cycle);
        end else begin
            check_cycles("o_reg_ack cycle", req_cycle, ack_cycle);
        end
    endtask

    // Status inputs held 3 cycles to get through the synchronizers
    task automatic set_status(input reg_data_t bits);
        init_done    = bits[8];
        dram_temp    = bits[7:1];
        dram_cattrip = bits[0];
        repeat (3) begin
            @(posedge clk);
            #2;
        end
    endtask

    // Control write, then the local reset rise or its hold time
    task automatic soft_reset_write(input host_addr_t addr, input reg_data_t wdata);
        reg_data_t rdata;
        logic      err;
        int        req_cycle;
        int        ack_cycle;
        int        waited;
        host_access(1'b1, addr, wdata, rdata, err, req_cycle, ack_cycle);
        if (timed_out) begin
            return;
        end
        check_err("o_reg_err", 1'b0, err);
        if (wdata[0]) begin
            check_err("o_local_reset", 1'b1, local_reset);
        end else begin
            waited = 0;
            while (local_reset && waited < TIMEOUT) begin
                @(posedge clk);
                #2;
                waited++;
            end
            if (local_reset) begin
                report_timeout("Timeout, o_local_reset stuck high after soft reset clear");
            end else begin
                check_cycles("o_local_reset hold", `HBM_RESET_HOLD, cycle_cnt - req_cycle);
            end
        end
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        logic [3:0] op;
        host_addr_t addr;
        reg_data_t  wdata;
        int         waited;
        reg_req      = 1'b0;
        reg_wr       = 1'b0;
        reg_addr     = '0;
        reg_wdata    = '0;
        init_done    = 1'b0;
        dram_cattrip = 1'b0;
        dram_temp    = '0;
        error_count  = 0;
        timed_out    = 1'b0;
        i_reset      = 1'b1;
        // End marker in every unused slot
        for (int i = 0; i < MAX_VEC; i++) begin
            vectors[i] = {4'hF, 96'h0};
        end
        $readmemh("dv/hbm_ctrl_vectors.txt", vectors);
        repeat (2) @(posedge clk);
        #2;
        i_reset = 1'b0;

        // Wait out the local reset hold
        waited = 0;
        while (local_reset && waited < TIMEOUT) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (local_reset) begin
            report_timeout("Timeout, o_local_reset stuck high after reset");
        end

        for (int v = 0; v < MAX_VEC && !timed_out; v++) begin
            op    = vectors[v][99:96];
            addr  = vectors[v][95:76];
            wdata = vectors[v][75:44];
            if (op == 4'hF) begin
                break;
            end
            case (op)
                4'h0: run_access(1'b1, addr, wdata, vectors[v][43:12], vectors[v][8],
                                 vectors[v][4:0]);
                4'h1: run_access(1'b0, addr, wdata, vectors[v][43:12], vectors[v][8],
                                 vectors[v][4:0]);
                4'h2: set_status(wdata);
                4'h3: soft_reset_write(addr, wdata);
                default: begin
                    error_count++;
                    $display("Vector %0d has an unknown operation code %0h", v, op);
                end
            endcase
        end

        $display("Run complete with %0d errors", error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule : hbm_ctrl_tb

// File: dv/hbm_ctrl_vectors.txt
// Columns in hex: op_addr_wdata_expected-rdata_expected-err_expected-paddr-code
// op 0 write, 1 read, 2 status inputs {init_done, temp, cattrip} in wdata, 3 soft reset write
2_00000_00000155_00000000_0_00
1_00004_00000000_00000002_0_00
1_00008_00000000_00000055_0_00
0_00004_FFFFFFFF_00000000_0_00
1_00004_00000000_00000002_0_00
0_00008_FFFFFFFF_00000000_0_00
1_00008_00000000_00000055_0_00
0_0000C_0000000D_00000000_0_00
1_0000C_00000000_00000005_0_00
3_00000_00000001_00000000_0_00
1_00000_00000000_00000001_0_00
1_00004_00000000_00000003_0_00
3_00000_00000000_00000000_0_00
1_00000_00000000_00000000_0_00
1_00004_00000000_00000002_0_00
1_00010_00000000_00000000_1_00
0_00014_00000001_00000000_1_00
2_00000_00000022_00000000_0_00
1_00008_00000000_00000022_0_00
1_00004_00000000_00000000_0_00
0_0000C_00000000_00000000_0_00
0_80010_A0000010_00000000_0_08
1_80010_00000000_A0000010_0_08
0_0000C_00000001_00000000_0_00
0_80020_A1000020_00000000_0_0C
1_80020_00000000_A1000020_0_0C
0_0000C_00000002_00000000_0_00
0_80030_A2000030_00000000_0_09
1_80030_00000000_A2000030_0_09
0_0000C_00000003_00000000_0_00
0_8A5C4_A30005C4_00000000_0_0D
1_8A5C4_00000000_A30005C4_0_0D
0_0000C_00000004_00000000_0_00
0_80050_A4000050_00000000_0_0A
1_80050_00000000_A4000050_0_0A
0_0000C_00000005_00000000_0_00
0_80060_A5000060_00000000_0_0E
1_80060_00000000_A5000060_0_0E
0_0000C_00000006_00000000_0_00
0_80070_A6000070_00000000_0_0B
1_80070_00000000_A6000070_0_0B
0_0000C_00000007_00000000_0_00
0_8FFFC_A700FFFC_00000000_0_0F
1_8FFFC_00000000_A700FFFC_0_0F
0_90004_12345678_00000000_1_0F
1_90004_00000000_00000000_1_0F

// File: flist.f
+incdir+hw
hw/hbm_ctrl_pkg.sv
hw/hbm_host_if.sv
hw/hbm_ctrl_decoder.sv
hw/hbm_ctrl_regs.sv
hw/hbm_apb_bridge.sv
hw/hbm_ctrl_top.sv
dv/hbm_ctrl_props.sv
dv/hbm_ctrl_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the HBM management testbench with Verilator, run it and check the log
set -eo pipefail

cd "$(dirname "$0")"
LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f flist.f --top-module hbm_ctrl_tb -o sim_hbm_ctrl
./obj_dir/sim_hbm_ctrl 2>&1 | tee "$LOG"

if grep -q "SOME TESTS FAILED" "$LOG"; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"
